// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only -Wall --timing
TOP       = tb_lsu_mem
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Verification passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
lsu_pkg.sv
lsu_req_decode.sv
sram_be.sv
lsu_load_align.sv
lsu_mem_top.sv
lsu_mem_checker.sv
tb_lsu_mem.sv

// File: lsu_load_align.sv
// Load aligner: lane extract, size mask, sign or zero extension, registered response

`timescale 1ns/100ps

module lsu_load_align
(
   input  logic                          CLK,
   input  logic                          rst_n,
   input  logic                          ctl_valid,
   input  lsu_pkg::load_ctl_t            ctl,
   input  logic [lsu_pkg::DATA_W-1:0]    ram_dout,
   output logic                          resp_valid,
   output lsu_pkg::load_resp_t           resp
);

   import lsu_pkg::*;

   logic [DATA_W-1:0] shifted;
   logic [DATA_W-1:0] ext_data;
   logic              resp_valid_q;
   load_resp_t        resp_q;

   // Addressed bytes down to lane zero
   assign shifted = ram_dout >> {ctl.offset, 3'b000};

   // Keep the access bytes, fill upper bits by the sign rule
   always_comb
   begin
      case (ctl.size)
         SIZE_B:
         begin
            if (ctl.is_signed)
               ext_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            else
               ext_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
         end
         SIZE_H:
         begin
            if (ctl.is_signed)
               ext_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            else
               ext_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
         end
         SIZE_W:
         begin
            if (ctl.is_signed)
               ext_data = {{(DATA_W-32){shifted[31]}}, shifted[31:0]};
            else
               ext_data = {{(DATA_W-32){1'b0}}, shifted[31:0]};
         end
         default:
         begin
            // Full word, no offset possible once aligned
            ext_data = shifted;
         end
      endcase
   end

   // Response strobe
   always_ff @(posedge CLK)
   begin
      if (!rst_n)
         resp_valid_q <= 1'b0;
      else
         resp_valid_q <= ctl_valid;
   end

   // Result data, only loaded for a real load
   always_ff @(posedge CLK)
   begin
      if (ctl_valid)
         resp_q.data <= ext_data;
   end

   assign resp_valid = resp_valid_q;
   assign resp       = resp_q;

endmodule

// File: lsu_mem_checker.sv
// Testbench checker: byte-array reference model, misalign and load result comparison

`timescale 1ns/100ps

module lsu_mem_checker
(
   input  logic                  CLK,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  lsu_pkg::mem_req_t     req,
   input  logic                  resp_valid,
   input  lsu_pkg::load_resp_t   resp,
   input  logic                  misalign,
   output int                    pending,
   output int                    error_count
);

   import lsu_pkg::*;

   // Reference memory, one entry per byte
   logic [7:0]        model [1 << BYTE_ADDR_W];
   // Load pipe, index 0 seen one edge ago, index 1 two edges ago
   logic [1:0]        ld_v = 2'b00;
   logic [DATA_W-1:0] ld_exp [2];
   logic              mis_exp = 1'b0;
   logic              prev_rst_n = 1'b1;
   int                pend_cnt = 0;
   int                err_cnt = 0;

   assign pending     = pend_cnt;
   assign error_count = err_cnt;

   // Natural alignment on the access size
   function automatic bit is_aligned(input mem_req_t r);
      return (int'(r.addr) % (1 << int'(r.size))) == 0;
   endfunction

   // Gather bytes little-endian, then extend by the sign rule
   function automatic logic [DATA_W-1:0] expect_load(input mem_req_t r);
      int                nbytes;
      logic [DATA_W-1:0] val;
      nbytes = 1 << r.size;
      val    = '0;
      for (int i = 0; i < nbytes; i++)
         val[i*8 +: 8] = model[int'(r.addr) + i];
      if (r.is_signed && nbytes < 8 && val[nbytes*8-1])
      begin
         for (int i = nbytes; i < 8; i++)
            val[i*8 +: 8] = 8'hff;
      end
      return val;
   endfunction

   always @(posedge CLK)
   begin
      if (!prev_rst_n)
      begin
         // Reset flops cleared by the previous edge
         if (resp_valid !== 1'b0 || misalign !== 1'b0)
         begin
            $display("Outputs not quiet during or right after reset at %0t", $time);
            err_cnt++;
         end
      end
      else if (rst_n)
      begin
         if (misalign !== mis_exp)
         begin
            $display("%s misalign pulse at %0t", mis_exp ? "Missing" : "Unexpected", $time);
            err_cnt++;
         end
         if (resp_valid !== ld_v[1])
         begin
            $display("%s resp_valid pulse at %0t", ld_v[1] ? "Missing" : "Unexpected", $time);
            err_cnt++;
         end
         else if (ld_v[1] && resp.data !== ld_exp[1])
         begin
            $display("ERROR %0t resp.data expected %h actual %h", $time, ld_exp[1], resp.data);
            err_cnt++;
         end
         if (mis_exp)
            pend_cnt--;
         if (ld_v[1])
            pend_cnt--;
      end
      // Advance the expectation pipe
      ld_v[1]   = ld_v[0];
      ld_exp[1] = ld_exp[0];
      ld_v[0]   = 1'b0;
      mis_exp   = 1'b0;
      if (!rst_n)
      begin
         // In-flight results are lost on reset
         ld_v     = 2'b00;
         pend_cnt = 0;
      end
      else if (req_valid)
      begin
         if (!is_aligned(req))
         begin
            mis_exp = 1'b1;
            pend_cnt++;
         end
         else if (req.is_store)
         begin
            for (int i = 0; i < (1 << req.size); i++)
               model[int'(req.addr) + i] = req.wdata[i*8 +: 8];
         end
         else
         begin
            ld_v[0]   = 1'b1;
            ld_exp[0] = expect_load(req);
            pend_cnt++;
         end
      end
      prev_rst_n = rst_n;
   end

endmodule

// File: lsu_mem_top.sv
// LSU data-memory top: decoder, byte-enabled RAM and load aligner

`timescale 1ns/100ps

module lsu_mem_top
(
   input  logic                  CLK,
   input  logic                  rst_n,
   input  logic                  req_valid,
   input  lsu_pkg::mem_req_t     req,
   output logic                  resp_valid,
   output lsu_pkg::load_resp_t   resp,
   output logic                  misalign
);

   import lsu_pkg::*;

   // Decoder to RAM
   logic [WORD_ADDR_W-1:0] ram_addr;
   logic                   ram_re;
   logic [BYTES_W-1:0]     ram_we;
   logic [DATA_W-1:0]      ram_din;
   // RAM to aligner
   logic [DATA_W-1:0]      ram_dout;
   // Decoder to aligner
   logic                   ctl_valid;
   load_ctl_t              ctl;

   lsu_req_decode u_req_decode
   (
      .CLK       (CLK),
      .rst_n     (rst_n),
      .req_valid (req_valid),
      .req       (req),
      .ram_addr  (ram_addr),
      .ram_re    (ram_re),
      .ram_we    (ram_we),
      .ram_din   (ram_din),
      .ctl_valid (ctl_valid),
      .ctl       (ctl),
      .misalign  (misalign)
   );

   sram_be u_sram
   (
      .CLK  (CLK),
      .addr (ram_addr),
      .re   (ram_re),
      .we   (ram_we),
      .din  (ram_din),
      .dout (ram_dout)
   );

   lsu_load_align u_load_align
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .ctl_valid  (ctl_valid),
      .ctl        (ctl),
      .ram_dout   (ram_dout),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

// File: lsu_pkg.sv
// Shared LSU geometry, access-size encoding, request, load-control and response structs

package lsu_pkg;

   // Data path geometry
   localparam int DATA_W      = 64;
   // 4 KiB byte-addressed space
   localparam int BYTE_ADDR_W = 12;
   // Byte offset bits inside one word
   localparam int LANE_W      = 3;
   // RAM word index bits
   localparam int WORD_ADDR_W = BYTE_ADDR_W - LANE_W;
   // Byte lanes per word
   localparam int BYTES_W     = DATA_W / 8;
   // RAM depth in words
   localparam int MEM_WORDS   = 1 << WORD_ADDR_W;

   // Access size, log2 of the byte count
   typedef enum logic [1:0] {
      SIZE_B = 2'd0,
      SIZE_H = 2'd1,
      SIZE_W = 2'd2,
      SIZE_D = 2'd3
   } access_size_e;

   // One load or store request, 80 bits
   typedef struct packed {
      logic [BYTE_ADDR_W-1:0] addr;
      access_size_e           size;
      logic                   is_store;
      logic                   is_signed;
      // Store value, right-justified
      logic [DATA_W-1:0]      wdata;
   } mem_req_t;

   // Load info staged alongside the RAM read, 6 bits
   typedef struct packed {
      logic [LANE_W-1:0] offset;
      access_size_e      size;
      logic              is_signed;
   } load_ctl_t;

   // Load result, already extended to full width
   typedef struct packed {
      logic [DATA_W-1:0] data;
   } load_resp_t;

endpackage

// File: lsu_req_decode.sv
// Request decoder: alignment check, byte write mask, store lane shift, staged load control

`timescale 1ns/100ps

module lsu_req_decode
(
   input  logic                              CLK,
   input  logic                              rst_n,
   input  logic                              req_valid,
   input  lsu_pkg::mem_req_t                 req,
   output logic [lsu_pkg::WORD_ADDR_W-1:0]   ram_addr,
   output logic                              ram_re,
   output logic [lsu_pkg::BYTES_W-1:0]       ram_we,
   output logic [lsu_pkg::DATA_W-1:0]        ram_din,
   output logic                              ctl_valid,
   output lsu_pkg::load_ctl_t                ctl,
   output logic                              misalign
);

   import lsu_pkg::*;

   logic [LANE_W-1:0]  offset;
   logic [LANE_W-1:0]  low_mask;
   logic [BYTES_W-1:0] size_mask;
   logic               aligned;
   logic               load_go;
   logic               store_go;
   logic               ctl_valid_q;
   logic               misalign_q;
   load_ctl_t          ctl_q;

   // Byte position inside the addressed word
   assign offset = req.addr[LANE_W-1:0];

   // Low address bits that must be zero, and lanes touched at offset zero
   always_comb
   begin
      case (req.size)
         SIZE_B:
         begin
            low_mask  = 3'b000;
            size_mask = 8'b0000_0001;
         end
         SIZE_H:
         begin
            low_mask  = 3'b001;
            size_mask = 8'b0000_0011;
         end
         SIZE_W:
         begin
            low_mask  = 3'b011;
            size_mask = 8'b0000_1111;
         end
         default:
         begin
            low_mask  = 3'b111;
            size_mask = 8'b1111_1111;
         end
      endcase
   end

   assign aligned  = ((offset & low_mask) == '0);
   // Only aligned requests reach the RAM
   assign load_go  = req_valid & aligned & ~req.is_store;
   assign store_go = req_valid & aligned & req.is_store;

   // RAM side, combinational in the request cycle
   assign ram_addr = req.addr[BYTE_ADDR_W-1:LANE_W];
   assign ram_re   = load_go;
   assign ram_we   = store_go ? (size_mask << offset) : '0;
   // Store bytes moved up to their lanes
   assign ram_din  = req.wdata << {offset, 3'b000};

   // Valid and misalign flags, cleared on reset
   always_ff @(posedge CLK)
   begin
      if (!rst_n)
      begin
         ctl_valid_q <= 1'b0;
         misalign_q  <= 1'b0;
      end
      else
      begin
         ctl_valid_q <= load_go;
         misalign_q  <= req_valid & ~aligned;
      end
   end

   // Load info for the aligner, meets the RAM read one cycle later
   always_ff @(posedge CLK)
   begin
      if (load_go)
      begin
         ctl_q.offset    <= offset;
         ctl_q.size      <= req.size;
         ctl_q.is_signed <= req.is_signed;
      end
   end

   assign ctl_valid = ctl_valid_q;
   assign ctl       = ctl_q;
   assign misalign  = misalign_q;

endmodule

// File: sram_be.sv
// Single-port RAM with per-byte write mask, registered read and held read address

`timescale 1ns/100ps

module sram_be
(
   input  logic                              CLK,
   input  logic [lsu_pkg::WORD_ADDR_W-1:0]   addr,
   input  logic                              re,
   input  logic [lsu_pkg::BYTES_W-1:0]       we,
   input  logic [lsu_pkg::DATA_W-1:0]        din,
   output logic [lsu_pkg::DATA_W-1:0]        dout
);

   import lsu_pkg::*;

   logic [DATA_W-1:0]      mem [MEM_WORDS];
   logic [WORD_ADDR_W-1:0] rd_addr_q;
   logic [WORD_ADDR_W-1:0] rd_addr;
   logic [DATA_W-1:0]      rd_data_q;

   // Read address, new on re, otherwise the last one read
   assign rd_addr = re ? addr : rd_addr_q;

   always_ff @(posedge CLK)
   begin
      if (re)
         rd_addr_q <= addr;
   end

   // Array is read every cycle at the held address
   // Old data on a same-cycle write, new data from the next read on
   always_ff @(posedge CLK)
   begin
      rd_data_q <= mem[rd_addr];
   end

   assign dout = rd_data_q;

   // Byte-lane writes
   always_ff @(posedge CLK)
   begin
      for (int i = 0; i < BYTES_W; i++)
      begin
         if (we[i])
            mem[addr][i*8 +: 8] <= din[i*8 +: 8];
      end
   end

endmodule

// File: tb_lsu_mem.sv
// Testbench top: clock, reset, seeded random requests, test sequence and summary

`timescale 1ns/100ps

module tb_lsu_mem;

   import lsu_pkg::*;

   logic       CLK;
   logic       rst_n;
   logic       req_valid;
   mem_req_t   req;
   logic       resp_valid;
   load_resp_t resp;
   logic       misalign;
   int         pending;
   int         error_count;
   int         tb_errors = 0;
   int         failed_tests = 0;
   // Error total at the start of the running test
   int         mark = 0;

   lsu_mem_top u_lsu_mem_top
   (
      .CLK        (CLK),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .resp_valid (resp_valid),
      .resp       (resp),
      .misalign   (misalign)
   );

   lsu_mem_checker u_checker
   (
      .CLK         (CLK),
      .rst_n       (rst_n),
      .req_valid   (req_valid),
      .req         (req),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .misalign    (misalign),
      .pending     (pending),
      .error_count (error_count)
   );

   // 40 ns period
   initial
   begin
      CLK = 1'b0;
      forever #20 CLK = ~CLK;
   end

   // One request in the next cycle with random store data
   task automatic send_req(input logic [11:0] addr, input access_size_e size,
                           input logic is_store, input logic is_signed);
      @(posedge CLK);
      req_valid <= 1'b1;
      req       <= '{addr: addr, size: size, is_store: is_store, is_signed: is_signed,
                     wdata: {$urandom(), $urandom()}};
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(posedge CLK);
         req_valid <= 1'b0;
      end
   endtask

   // Reset held for 16 cycles with requests off
   task automatic apply_reset();
      @(posedge CLK);
      rst_n     <= 1'b0;
      req_valid <= 1'b0;
      repeat (16) @(posedge CLK);
      rst_n <= 1'b1;
   endtask

   // Random address aligned to the size
   function automatic logic [11:0] aligned_addr(input access_size_e size);
      logic [31:0] r;
      r = $urandom();
      return r[11:0] & ~((12'd1 << size) - 12'd1);
   endfunction

   // Drain outstanding results and print one result line
   task automatic finish_test(input string name);
      int waited;
      idle_cycles(1);
      waited = 0;
      @(negedge CLK);
      while (pending != 0 && waited < 200)
      begin
         @(negedge CLK);
         waited++;
      end
      if (pending != 0)
      begin
         $display("Timeout in %s: %0d expected results never arrived", name, pending);
         tb_errors++;
      end
      if (error_count + tb_errors == mark)
         $display("Test %s: PASS", name);
      else
      begin
         $display("Test %s: FAIL", name);
         failed_tests++;
      end
      mark = error_count + tb_errors;
   endtask

   task automatic fill_and_read();
      for (int w = 0; w < MEM_WORDS; w++)
         send_req({w[8:0], 3'b000}, SIZE_D, 1'b1, 1'b0);
      for (int w = 0; w < MEM_WORDS; w++)
         send_req({w[8:0], 3'b000}, SIZE_D, 1'b0, 1'b0);
   endtask

   task automatic mixed_traffic();
      logic [31:0]  r;
      access_size_e sz;
      for (int i = 0; i < 400; i++)
      begin
         r  = $urandom();
         sz = access_size_e'(r[1:0]);
         send_req(aligned_addr(sz), sz, r[2], r[3]);
         // Occasional short gap
         if (r[7:4] == 4'd0)
            idle_cycles(int'(r[9:8]));
      end
   endtask

   task automatic misaligned_access();
      logic [31:0]  r;
      logic [11:0]  a;
      access_size_e sz;
      logic [11:0]  words [$];
      for (int i = 0; i < 100; i++)
      begin
         r  = $urandom();
         // Halfword or wider since bytes never misalign
         sz = access_size_e'((r[1:0] == 2'd0) ? 2'd1 : r[1:0]);
         a  = r[23:12];
         if ((a & ((12'd1 << sz) - 12'd1)) == 12'd0)
            a[0] = 1'b1;
         send_req(a, sz, r[2], r[3]);
         words.push_back({a[11:3], 3'b000});
      end
      // Words must be untouched
      foreach (words[i])
         send_req(words[i], SIZE_D, 1'b0, 1'b0);
   endtask

   task automatic back_to_back();
      logic [31:0]  r;
      logic [11:0]  a;
      access_size_e sz;
      for (int i = 0; i < 100; i++)
      begin
         r  = $urandom();
         sz = access_size_e'(r[1:0]);
         a  = aligned_addr(sz);
         send_req(a, sz, 1'b1, 1'b0);
         // Same word read in the very next cycle
         send_req({a[11:3], 3'b000}, SIZE_D, 1'b0, r[2]);
         send_req(aligned_addr(SIZE_W), SIZE_W, 1'b0, r[3]);
      end
   endtask

   task automatic quiet_outputs();
      logic [31:0]  r;
      access_size_e sz;
      for (int i = 0; i < 60; i++)
      begin
         r  = $urandom();
         sz = access_size_e'(r[1:0]);
         idle_cycles(int'(r[5:3]));
         // Store-only stretch
         repeat (int'(r[8:6]))
            send_req(aligned_addr(sz), sz, 1'b1, 1'b0);
         if (r[9])
            send_req(aligned_addr(sz), sz, 1'b0, r[10]);
      end
      // Reset lands on an in-flight load and a misaligned request
      send_req(aligned_addr(SIZE_D), SIZE_D, 1'b0, 1'b0);
      send_req(12'h001, SIZE_H, 1'b0, 1'b0);
      rst_n <= 1'b0;
      apply_reset();
   endtask

   initial
   begin
      void'($urandom(32'he1f7));
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      apply_reset();
      fill_and_read();
      finish_test("fill and read back");
      mixed_traffic();
      finish_test("random mixed traffic");
      misaligned_access();
      finish_test("misalignment");
      back_to_back();
      finish_test("back-to-back pipeline");
      quiet_outputs();
      finish_test("quiet outputs");
      $display("Tests run 5, failed %0d, checker errors %0d, testbench errors %0d",
               failed_tests, error_count, tb_errors);
      if (failed_tests == 0 && error_count == 0 && tb_errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule
